// File: bench/cmd_mover_tb.sv
// Testbench for the command mover with random commands checked against a memory and stream model
`timescale 1ns/1ns

module cmd_mover_tb
    import cmd_mover_pkg::*;
();

    localparam int SEED      = 3000;
    localparam int TIMEOUT   = 2000;
    localparam int MEM_WORDS = 256;

    logic         aclk = 1'b0;
    logic         resetn;
    logic         in_valid;
    logic         in_ready;
    stream_beat_t in_beat;
    logic         out_valid;
    logic         out_ready = 1'b0;
    stream_beat_t out_beat;

    integer data_seed  = SEED;
    integer ready_seed = SEED;
    logic   stall_mode = 1'b0;

    // Reference model state
    word_t        mem_model [0:MEM_WORDS-1];
    stream_beat_t expected_q [$];

    cmd_mover_top dut_i (
        .aclk      (aclk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #10 aclk = ~aclk;

    // Output backpressure, random only while stalling is enabled
    always @(posedge aclk)
    begin
        logic [31:0] r;
        r = $random(ready_seed);
        if (stall_mode)
        begin
            out_ready <= r[0];
        end
        else
        begin
            out_ready <= 1'b1;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Outputs are stable at the falling edge, and the transfer follows at the next rising edge
    always @(negedge aclk)
    begin
        if (resetn && out_valid && out_ready)
        begin
            if (expected_q.size() == 0)
            begin
                fail_run("Output beat arrived while no beat was expected");
            end
            else
            begin
                compare_value(out_beat.data, expected_q[0].data, "output data");
                compare_value(word_t'(out_beat.last), word_t'(expected_q[0].last), "output last");
                void'(expected_q.pop_front());
            end
        end
    end

    function automatic int rand_below(input int limit);
        logic [31:0] r;
        r = $random(data_seed);
        return int'(r % limit);
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = $random(data_seed);
        return w;
    endfunction

    // Word index into the model, wrapping like the 10-bit byte address
    function automatic logic [7:0] wrap_index(input int base, input int offset);
        int sum;
        sum = base + offset;
        return sum[7:0];
    endfunction

    // Opcode on top, byte count below with optional odd low bits
    function automatic word_t command_word(input opcode_e op, input int beats, input int extra);
        word_t w;
        w        = '0;
        w[31:28] = op;
        w[27:2]  = beats[25:0];
        w[1:0]   = extra[1:0];
        return w;
    endfunction

    function automatic word_t address_word(input int base);
        word_t w;
        w      = '0;
        w[9:2] = wrap_index(base, 0);
        return w;
    endfunction

    // Called at a rising edge, returns at the edge of the transfer
    task automatic send_word(input word_t w);
        int waited;
        waited = 0;
        in_valid     <= 1'b1;
        in_beat.data <= w;
        in_beat.last <= 1'b0;
        @(negedge aclk);
        while (!in_ready && (waited < TIMEOUT))
        begin
            waited = waited + 1;
            @(negedge aclk);
        end
        if (in_ready)
        begin
            @(posedge aclk);
        end
        else
        begin
            fail_run("Timed out waiting for in_ready");
        end
    endtask

    task automatic drain_output();
        int waited;
        waited = 0;
        in_valid <= 1'b0;
        while ((expected_q.size() != 0) && (waited < TIMEOUT))
        begin
            waited = waited + 1;
            @(negedge aclk);
        end
        if (expected_q.size() == 0)
        begin
            @(posedge aclk);
        end
        else
        begin
            fail_run("Timed out waiting for out_valid with beats still expected");
        end
    endtask

    task automatic issue_nop();
        send_word(command_word(OP_NOP, rand_below(64), rand_below(4)));
    endtask

    task automatic issue_stream(input int beats, input int extra);
        word_t        d;
        stream_beat_t b;
        send_word(command_word(OP_STREAM, beats, extra));
        for (int i = 0; i < beats; i++)
        begin
            d      = random_word();
            b.data = d;
            b.last = (i == beats - 1);
            expected_q.push_back(b);
            send_word(d);
        end
    endtask

    task automatic issue_store(input int base, input int beats);
        word_t d;
        send_word(command_word(OP_STORE, beats, rand_below(4)));
        send_word(address_word(base));
        for (int i = 0; i < beats; i++)
        begin
            d = random_word();
            mem_model[wrap_index(base, i)] = d;
            send_word(d);
        end
    endtask

    task automatic issue_load(input int base, input int beats);
        stream_beat_t b;
        send_word(command_word(OP_LOAD, beats, rand_below(4)));
        send_word(address_word(base));
        for (int i = 0; i < beats; i++)
        begin
            b.data = mem_model[wrap_index(base, i)];
            b.last = (i == beats - 1);
            expected_q.push_back(b);
        end
    endtask

    task automatic issue_memset(input int base, input int beats, input word_t value);
        send_word(command_word(OP_MEMSET, beats, rand_below(4)));
        send_word(address_word(base));
        send_word(value);
        for (int i = 0; i < beats; i++)
        begin
            mem_model[wrap_index(base, i)] = value;
        end
    endtask

    initial
    begin
        int base;
        int n;
        int op_pick;
        resetn   <= 1'b0;
        in_valid <= 1'b0;
        in_beat  <= '0;

        repeat (2) @(posedge aclk);
        resetn <= 1'b1;
        // Parser still in idle during the first cycle out of reset
        @(negedge aclk);
        compare_value(word_t'(out_valid), 32'd0, "out_valid after reset");
        compare_value(word_t'(in_ready), 32'd0, "in_ready in first cycle after reset");
        @(posedge aclk);

        // Known contents in every word before any load
        issue_store(0, MEM_WORDS);
        drain_output();

        issue_stream(0, 3);
        for (int k = 0; k < 4; k++)
        begin
            issue_stream(1 + rand_below(16), rand_below(4));
        end
        drain_output();

        for (int k = 0; k < 4; k++)
        begin
            base = rand_below(MEM_WORDS);
            n    = 1 + rand_below(24);
            issue_store(base, n);
            issue_load(base, n);
            drain_output();
        end

        // Fill, then read two words on each side of the range
        base = rand_below(MEM_WORDS);
        n    = 1 + rand_below(16);
        issue_memset(base, n, random_word());
        issue_load(base + MEM_WORDS - 2, n + 4);
        drain_output();

        issue_nop();
        issue_stream(1 + rand_below(8), 0);
        issue_nop();
        issue_nop();
        issue_load(rand_below(MEM_WORDS), 1 + rand_below(8));
        issue_nop();
        drain_output();

        stall_mode <= 1'b1;
        for (int k = 0; k < 60; k++)
        begin
            op_pick = rand_below(5);
            base    = rand_below(MEM_WORDS);
            n       = rand_below(20);
            case (op_pick)
                0: issue_nop();
                1: issue_stream(n, rand_below(4));
                2: issue_store(base, n);
                3: issue_load(base, n);
                default: issue_memset(base, n, random_word());
            endcase
        end
        drain_output();
        stall_mode <= 1'b0;

        // Quiet period so a stray beat still reaches the monitor
        repeat (20) @(posedge aclk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: cmd_mover.f
+incdir+design
design/cmd_mover_pkg.sv
design/addr_seq.sv
design/cmd_parser.sv
design/scratch_mem.sv
design/cmd_mover_top.sv
bench/cmd_mover_tb.sv

// File: design/addr_seq.sv
// Address sequencer that steps word addresses through a burst and flags the last one
`timescale 1ns/1ns

module addr_seq
    import cmd_mover_pkg::*;
(
    input  logic        aclk,
    input  logic        resetn,
    input  logic        seq_load,
    input  mem_addr_t   seq_start,
    input  beat_count_t seq_beats,
    input  logic        seq_step,
    output mem_addr_t   seq_addr,
    output logic        seq_final
);

    mem_addr_t   cur_addr;
    beat_count_t remaining;

    // Current word address, low byte bits forced to zero
    always_ff @(posedge aclk)
    begin
        if (seq_load)
        begin
            cur_addr <= seq_start & ~mem_addr_t'(3);
        end
        else if (seq_step)
        begin
            cur_addr <= cur_addr + mem_addr_t'(4);
        end
    end

    // Requests still to be issued, including the current one
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            remaining <= '0;
        end
        else if (seq_load)
        begin
            remaining <= seq_beats;
        end
        else if (seq_step)
        begin
            remaining <= remaining - beat_count_t'(1);
        end
    end

    assign seq_addr  = cur_addr;
    assign seq_final = (remaining == beat_count_t'(1));

    // The parser must stop stepping once the final address has gone out
    step_after_final: assert property (@(posedge aclk) disable iff (!resetn)
        seq_step |-> (remaining != '0));

endmodule

// File: design/cmd_mover_macros.svh
// Width and field position constants shared by the command mover blocks
`ifndef CMD_MOVER_MACROS_SVH
`define CMD_MOVER_MACROS_SVH

// Stream beat and memory word width
`define DATA_WIDTH 32

// Byte address width of the scratch memory (256 words)
`define MEM_ADDR_WIDTH 10

// Command word layout
// opcode in the top nibble, byte count below it
`define OP_POS 28
`define OP_SIZE 4
`define IMM_SIZE 28

`endif

// File: design/cmd_mover_pkg.sv
// Shared types of the command mover for opcodes, parser states, words and channel payloads
`include "cmd_mover_macros.svh"

package cmd_mover_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // Byte count divided by four
    typedef logic [`IMM_SIZE-3:0] beat_count_t;

    typedef enum logic [`OP_SIZE-1:0] {
        OP_NOP    = 4'd0,
        OP_STORE  = 4'd1,
        OP_LOAD   = 4'd2,
        OP_MEMSET = 4'd3,
        OP_STREAM = 4'd4
    } opcode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMMAND,
        ST_ADDR,
        ST_VALUE,
        ST_MOVE
    } parser_state_e;

    typedef struct packed {
        word_t data;
        logic  last;
    } stream_beat_t;

    typedef struct packed {
        mem_addr_t addr;
        word_t     data;
    } mem_wr_req_t;

endpackage

// File: design/cmd_mover_top.sv
// Command-driven data mover joining the parser, address sequencer and scratch memory
`timescale 1ns/1ns

module cmd_mover_top
    import cmd_mover_pkg::*;
(
    input  logic         aclk,
    input  logic         resetn,

    input  logic         in_valid,
    output logic         in_ready,
    input  stream_beat_t in_beat,

    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out_beat
);

    logic        wr_valid;
    logic        wr_ready;
    mem_wr_req_t wr_req;
    logic        rd_valid;
    logic        rd_ready;
    mem_addr_t   rd_addr;
    logic        rsp_valid;
    logic        rsp_ready;
    word_t       rsp_data;

    logic        seq_load;
    mem_addr_t   seq_start;
    beat_count_t seq_beats;
    logic        seq_step;
    mem_addr_t   seq_addr;
    logic        seq_final;

    cmd_parser u_parser (
        .aclk      (aclk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_req    (wr_req),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_addr   (rd_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .seq_load  (seq_load),
        .seq_start (seq_start),
        .seq_beats (seq_beats),
        .seq_step  (seq_step),
        .seq_addr  (seq_addr),
        .seq_final (seq_final)
    );

    addr_seq u_seq (
        .aclk      (aclk),
        .resetn    (resetn),
        .seq_load  (seq_load),
        .seq_start (seq_start),
        .seq_beats (seq_beats),
        .seq_step  (seq_step),
        .seq_addr  (seq_addr),
        .seq_final (seq_final)
    );

    scratch_mem u_mem (
        .aclk      (aclk),
        .resetn    (resetn),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_req    (wr_req),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_addr   (rd_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

endmodule

// File: design/cmd_parser.sv
// Command parser that decodes command words and moves beats between stream, memory and output
`timescale 1ns/1ns
`include "cmd_mover_macros.svh"

module cmd_parser
    import cmd_mover_pkg::*;
(
    input  logic         aclk,
    input  logic         resetn,

    input  logic         in_valid,
    output logic         in_ready,
    input  stream_beat_t in_beat,

    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out_beat,

    output logic         wr_valid,
    input  logic         wr_ready,
    output mem_wr_req_t  wr_req,

    output logic         rd_valid,
    input  logic         rd_ready,
    output mem_addr_t    rd_addr,

    input  logic         rsp_valid,
    output logic         rsp_ready,
    input  word_t        rsp_data,

    output logic         seq_load,
    output mem_addr_t    seq_start,
    output beat_count_t  seq_beats,
    output logic         seq_step,
    input  mem_addr_t    seq_addr,
    input  logic         seq_final
);

    parser_state_e state;
    opcode_e       opcode;
    beat_count_t   beats_left;
    word_t         fill_value;
    logic          issue_done;

    opcode_e       cmd_op;
    beat_count_t   cmd_beats;
    logic          in_xfer;
    logic          move_active;
    logic          src_valid;
    word_t         src_data;
    logic          to_output;
    logic          to_memory;
    logic          out_slot_free;
    logic          sink_ready;
    logic          take;
    logic          out_load;

    // Command word fields
    assign cmd_op    = opcode_e'(in_beat.data[`OP_POS +: `OP_SIZE]);
    assign cmd_beats = in_beat.data[`IMM_SIZE-1:2];

    assign in_xfer       = in_valid && in_ready;
    assign move_active   = (state == ST_MOVE) && (beats_left != '0);
    assign out_slot_free = !out_valid || out_ready;

    // Source and sink selection per opcode
    always_comb
    begin
        src_valid = 1'b0;
        src_data  = in_beat.data;
        to_output = 1'b0;
        to_memory = 1'b0;
        case (opcode)
            OP_STREAM:
            begin
                src_valid = in_valid;
                to_output = 1'b1;
            end
            OP_STORE:
            begin
                src_valid = in_valid;
                to_memory = 1'b1;
            end
            OP_MEMSET:
            begin
                src_valid = 1'b1;
                src_data  = fill_value;
                to_memory = 1'b1;
            end
            OP_LOAD:
            begin
                src_valid = rsp_valid;
                src_data  = rsp_data;
                to_output = 1'b1;
            end
            default:
            begin
                src_valid = 1'b0;
            end
        endcase
    end

    assign sink_ready = to_output ? out_slot_free : (to_memory && wr_ready);
    assign take       = move_active && src_valid && sink_ready;
    assign out_load   = take && to_output;

    // Command and parameter words are taken whenever the parser waits for one
    always_comb
    begin
        case (state)
            ST_COMMAND, ST_ADDR, ST_VALUE:
            begin
                in_ready = 1'b1;
            end
            ST_MOVE:
            begin
                in_ready = move_active && sink_ready &&
                           ((opcode == OP_STREAM) || (opcode == OP_STORE));
            end
            default:
            begin
                in_ready = 1'b0;
            end
        endcase
    end

    assign rsp_ready = move_active && (opcode == OP_LOAD) && sink_ready;

    assign wr_valid    = move_active && to_memory && src_valid;
    assign wr_req.addr = seq_addr;
    assign wr_req.data = src_data;

    // Read issue runs ahead of the response count
    assign rd_valid = (state == ST_MOVE) && (opcode == OP_LOAD) && !issue_done;
    assign rd_addr  = seq_addr;

    assign seq_load  = (state == ST_ADDR) && in_xfer;
    assign seq_start = in_beat.data[`MEM_ADDR_WIDTH-1:0];
    assign seq_beats = beats_left;
    assign seq_step  = (wr_valid && wr_ready) || (rd_valid && rd_ready);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state      <= ST_IDLE;
            opcode     <= OP_NOP;
            beats_left <= '0;
            issue_done <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    state <= ST_COMMAND;
                end
                ST_COMMAND:
                begin
                    if (in_xfer)
                    begin
                        opcode     <= cmd_op;
                        beats_left <= cmd_beats;
                        case (cmd_op)
                            OP_STORE, OP_LOAD, OP_MEMSET: state <= ST_ADDR;
                            OP_STREAM:                    state <= ST_MOVE;
                            default:                      state <= ST_IDLE;
                        endcase
                    end
                end
                ST_ADDR:
                begin
                    if (in_xfer)
                    begin
                        // Nothing to read for an empty range
                        issue_done <= (beats_left == '0);
                        state      <= (opcode == OP_MEMSET) ? ST_VALUE : ST_MOVE;
                    end
                end
                ST_VALUE:
                begin
                    if (in_xfer)
                    begin
                        state <= ST_MOVE;
                    end
                end
                ST_MOVE:
                begin
                    if (take)
                    begin
                        beats_left <= beats_left - beat_count_t'(1);
                    end
                    if (rd_valid && rd_ready && seq_final)
                    begin
                        issue_done <= 1'b1;
                    end
                    // Done once every beat has left the output register
                    if ((beats_left == '0) && out_slot_free)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // MEMSET fill value
    always_ff @(posedge aclk)
    begin
        if ((state == ST_VALUE) && in_xfer)
        begin
            fill_value <= in_beat.data;
        end
    end

    // One-entry output register
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
        end
        else if (out_load)
        begin
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (out_load)
        begin
            out_beat.data <= src_data;
            out_beat.last <= (beats_left == beat_count_t'(1));
        end
    end

    out_hold_stable: assert property (@(posedge aclk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

    wr_rd_exclusive: assert property (@(posedge aclk) disable iff (!resetn)
        !(wr_valid && rd_valid));

endmodule

// File: design/scratch_mem.sv
// Single-port scratch memory with write, read request and registered read response channels
`timescale 1ns/1ns
`include "cmd_mover_macros.svh"

module scratch_mem
    import cmd_mover_pkg::*;
(
    input  logic        aclk,
    input  logic        resetn,

    input  logic        wr_valid,
    output logic        wr_ready,
    input  mem_wr_req_t wr_req,

    input  logic        rd_valid,
    output logic        rd_ready,
    input  mem_addr_t   rd_addr,

    output logic        rsp_valid,
    input  logic        rsp_ready,
    output word_t       rsp_data
);

    localparam int WORD_BITS = `MEM_ADDR_WIDTH - 2;
    localparam int DEPTH     = 1 << WORD_BITS;

    word_t mem [0:DEPTH-1];

    logic rd_xfer;

    // Writes never stall
    assign wr_ready = 1'b1;

    // Response slot is free when empty or draining this cycle
    assign rd_ready = !rsp_valid || rsp_ready;
    assign rd_xfer  = rd_valid && rd_ready;

    // Word index is the byte address above bit 1
    always_ff @(posedge aclk)
    begin
        if (wr_valid)
        begin
            mem[wr_req.addr[`MEM_ADDR_WIDTH-1:2]] <= wr_req.data;
        end
        if (rd_xfer)
        begin
            rsp_data <= mem[rd_addr[`MEM_ADDR_WIDTH-1:2]];
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            rsp_valid <= 1'b0;
        end
        else if (rd_xfer)
        begin
            rsp_valid <= 1'b1;
        end
        else if (rsp_ready)
        begin
            rsp_valid <= 1'b0;
        end
    end

    // One port only, so the parser must never mix directions
    single_port_use: assert property (@(posedge aclk) disable iff (!resetn)
        !(wr_valid && wr_ready && rd_valid && rd_ready));

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the command mover testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f cmd_mover.f --top-module cmd_mover_tb -o cmd_mover_sim

./obj_dir/cmd_mover_sim
